// File: Makefile
SOURCES := $(wildcard hdl/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: obj_dir/Vpid_core_tb

# Rebuilt only when a source or the file list changes
obj_dir/Vpid_core_tb: vlog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module pid_core_tb \
		-f vlog.f -o Vpid_core_tb

# The log decides pass or fail, not the exit code of the simulator
run: obj_dir/Vpid_core_tb
	-obj_dir/Vpid_core_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/instr_dispatch.sv
`timescale 1ns/1ps

module instr_dispatch (
   input  logic                        clk_in,
   input  logic                        reset,
   input  logic                        head_valid,
   input  logic [pid_pkg::W_SRC-1:0]   head_src,
   input  logic [pid_pkg::W_DATA-1:0]  head_data,
   input  logic                        wr_en,
   input  pid_pkg::cfg_addr_t          wr_addr,
   input  logic [pid_pkg::W_CHAN-1:0]  wr_chan,
   input  logic [pid_pkg::W_DATA-1:0]  wr_data,
   output logic                        pop,
   instr_if.src                        instr
);

   // --------------------------------------------------
   // Routing table
   // --------------------------------------------------

   // Each output channel selects one ADC source, or NULL_SRC for none
   logic [pid_pkg::W_SRC:0]     src_sel [pid_pkg::N_CHAN];
   logic [pid_pkg::N_CHAN-1:0]  chan_en;

   // Only the routing opcodes are handled here, the filter takes the rest
   always_ff @(posedge clk_in) begin
      if (reset) begin
         for (int i = 0; i < pid_pkg::N_CHAN; i++) begin
            src_sel[i] <= pid_pkg::NULL_SRC;
         end
         chan_en <= '0;
      end else if (wr_en) begin
         case (wr_addr)
            pid_pkg::CFG_SRC_SEL: src_sel[wr_chan] <= wr_data[pid_pkg::W_SRC:0];
            pid_pkg::CFG_CHAN_EN: chan_en[wr_chan] <= wr_data[0];
            default: ;
         endcase
      end
   end

   // --------------------------------------------------
   // Channel search
   // --------------------------------------------------

   // Channels already served for the sample now at the FIFO head
   logic [pid_pkg::N_CHAN-1:0]  done;
   logic                        hit;
   logic [pid_pkg::W_CHAN-1:0]  sel_chan;

   // Scanning from the top down leaves the lowest matching channel selected
   always_comb begin
      hit      = 1'b0;
      sel_chan = '0;
      for (int i = pid_pkg::N_CHAN - 1; i >= 0; i--) begin
         if (src_sel[i] == {1'b0, head_src} && !done[i]) begin
            hit      = 1'b1;
            sel_chan = i[pid_pkg::W_CHAN-1:0];
         end
      end
   end

   // --------------------------------------------------
   // Credits and issue
   // --------------------------------------------------

   // Free result slots in the filter, the only credit check in the design
   logic [pid_pkg::W_CREDIT-1:0] credits;
   logic                         have_credit;
   logic                         advance;

   assign have_credit = (credits != '0);

   // A disabled channel is marked off without needing a credit
   assign advance = head_valid && hit && (!chan_en[sel_chan] || have_credit);

   // Issue only for enabled channels, and release the sample once nothing matches
   assign instr.valid = head_valid && hit && chan_en[sel_chan] && have_credit;
   assign instr.chan  = sel_chan;
   assign instr.data  = head_data;
   assign pop         = head_valid && !hit;

   always_ff @(posedge clk_in) begin
      if (reset) begin
         done <= '0;
      end else if (pop) begin
         // The next sample starts with every channel unserved
         done <= '0;
      end else if (advance) begin
         done[sel_chan] <= 1'b1;
      end
   end

   // A beat and a returned credit in one cycle cancel out
   always_ff @(posedge clk_in) begin
      if (reset) begin
         credits <= pid_pkg::CREDIT_INIT;
      end else begin
         case ({instr.valid, instr.credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

// File: hdl/instr_if.sv
`timescale 1ns/1ps

// --------------------------------------------------
// Credit-based instruction channel, dispatcher to filter
// --------------------------------------------------
interface instr_if;

   // One instruction beat per cycle that valid is high
   logic                        valid;
   logic [pid_pkg::W_CHAN-1:0]  chan;
   logic [pid_pkg::W_DATA-1:0]  data;

   // Single-cycle pulse from the filter, one per freed result slot
   logic                        credit;

   // The dispatcher side spends credits
   modport src (
      output valid,
      output chan,
      output data,
      input  credit
   );

   // The filter side returns them
   modport dst (
      input  valid,
      input  chan,
      input  data,
      output credit
   );

endinterface

// File: hdl/pid_core_top.sv
`timescale 1ns/1ps

module pid_core_top (
   input  logic                        clk_in,
   input  logic                        reset,
   input  logic                        in_valid,
   input  logic [pid_pkg::W_SRC-1:0]   in_src,
   input  logic [pid_pkg::W_DATA-1:0]  in_data,
   input  logic                        wr_en,
   input  pid_pkg::cfg_addr_t          wr_addr,
   input  logic [pid_pkg::W_CHAN-1:0]  wr_chan,
   input  logic [pid_pkg::W_DATA-1:0]  wr_data,
   input  logic                        res_ready,
   output logic                        in_full,
   output logic                        res_valid,
   output logic [pid_pkg::W_CHAN-1:0]  res_chan,
   output logic [pid_pkg::W_ACC-1:0]   res_data
);

   // --------------------------------------------------
   // FIFO head to dispatcher
   // --------------------------------------------------
   logic                        head_valid;
   logic [pid_pkg::W_SRC-1:0]   head_src;
   logic [pid_pkg::W_DATA-1:0]  head_data;
   logic                        head_pop;

   // Credited instruction path from dispatcher to filter
   instr_if instr_bus ();

   // Tagged ADC samples wait here until every routed channel is served
   sample_fifo fifo0 (
      .clk_in     (clk_in),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_src     (in_src),
      .in_data    (in_data),
      .pop        (head_pop),
      .head_valid (head_valid),
      .head_src   (head_src),
      .head_data  (head_data),
      .full       (in_full)
   );

   // Fans each sample out into one instruction per routed channel
   instr_dispatch dispatch0 (
      .clk_in     (clk_in),
      .reset      (reset),
      .head_valid (head_valid),
      .head_src   (head_src),
      .head_data  (head_data),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_chan    (wr_chan),
      .wr_data    (wr_data),
      .pop        (head_pop),
      .instr      (instr_bus.src)
   );

   // PI arithmetic and the result buffer that owns the credits
   pid_filter filter0 (
      .clk_in     (clk_in),
      .reset      (reset),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_chan    (wr_chan),
      .wr_data    (wr_data),
      .res_ready  (res_ready),
      .instr      (instr_bus.dst),
      .res_valid  (res_valid),
      .res_chan   (res_chan),
      .res_data   (res_data)
   );

endmodule

// File: hdl/pid_filter.sv
`timescale 1ns/1ps

module pid_filter (
   input  logic                        clk_in,
   input  logic                        reset,
   input  logic                        wr_en,
   input  pid_pkg::cfg_addr_t          wr_addr,
   input  logic [pid_pkg::W_CHAN-1:0]  wr_chan,
   input  logic [pid_pkg::W_DATA-1:0]  wr_data,
   input  logic                        res_ready,
   instr_if.dst                        instr,
   output logic                        res_valid,
   output logic [pid_pkg::W_CHAN-1:0]  res_chan,
   output logic [pid_pkg::W_ACC-1:0]   res_data
);

   // --------------------------------------------------
   // Per-channel configuration
   // --------------------------------------------------
   logic signed [pid_pkg::W_DATA-1:0] setpoint [pid_pkg::N_CHAN];
   logic [pid_pkg::W_KP-1:0]          kp       [pid_pkg::N_CHAN];

   // Setpoint and gain only, routing opcodes belong to the dispatcher
   always_ff @(posedge clk_in) begin
      if (reset) begin
         for (int i = 0; i < pid_pkg::N_CHAN; i++) begin
            setpoint[i] <= '0;
            kp[i]       <= '0;
         end
      end else if (wr_en) begin
         case (wr_addr)
            pid_pkg::CFG_SETPOINT: setpoint[wr_chan] <= $signed(wr_data);
            pid_pkg::CFG_KP:       kp[wr_chan] <= wr_data[pid_pkg::W_KP-1:0];
            default: ;
         endcase
      end
   end

   // --------------------------------------------------
   // Stage one, error and proportional term
   // --------------------------------------------------
   logic signed [pid_pkg::W_ACC-1:0] sample_ext;
   logic signed [pid_pkg::W_ACC-1:0] setpoint_ext;
   logic signed [pid_pkg::W_ACC-1:0] err;
   logic signed [pid_pkg::W_ACC-1:0] prod;

   // Both operands are sign-extended so the error is exact before any wrap
   assign sample_ext   = $signed(instr.data);
   assign setpoint_ext = setpoint[instr.chan];
   assign err          = sample_ext - setpoint_ext;

   // Gain gets a zero sign bit so the multiply stays signed
   assign prod = err * $signed({1'b0, kp[instr.chan]});

   logic                             s1_valid;
   logic [pid_pkg::W_CHAN-1:0]       s1_chan;
   logic signed [pid_pkg::W_ACC-1:0] s1_err;
   logic signed [pid_pkg::W_ACC-1:0] s1_prod;

   always_ff @(posedge clk_in) begin
      if (reset) s1_valid <= 1'b0;
      else       s1_valid <= instr.valid;
   end

   always_ff @(posedge clk_in) begin
      s1_chan <= instr.chan;
      s1_err  <= err;
      s1_prod <= prod;
   end

   // --------------------------------------------------
   // Stage two, integrator and result
   // --------------------------------------------------
   logic signed [pid_pkg::W_ACC-1:0] integ [pid_pkg::N_CHAN];
   logic signed [pid_pkg::W_ACC-1:0] new_integ;
   logic signed [pid_pkg::W_ACC-1:0] result;

   // Read and write back happen in this one stage, so back-to-back beats
   // on the same channel always see the latest integrator
   assign new_integ = integ[s1_chan] + s1_err;
   assign result    = s1_prod + new_integ;

   always_ff @(posedge clk_in) begin
      if (reset) begin
         for (int i = 0; i < pid_pkg::N_CHAN; i++) begin
            integ[i] <= '0;
         end
      end else if (s1_valid) begin
         integ[s1_chan] <= new_integ;
      end
   end

   // --------------------------------------------------
   // Result buffer
   // --------------------------------------------------
   logic [pid_pkg::W_CHAN-1:0]   buf_chan [pid_pkg::N_CREDIT];
   logic [pid_pkg::W_ACC-1:0]    buf_data [pid_pkg::N_CREDIT];
   logic [pid_pkg::W_RES_PTR-1:0] buf_wr_ptr;
   logic [pid_pkg::W_RES_PTR-1:0] buf_rd_ptr;
   logic [pid_pkg::W_RES_PTR:0]   buf_count;
   logic                          res_pop;

   // Credits keep the buffer from overflowing, so pushes are never refused
   assign res_valid = (buf_count != '0);
   assign res_chan  = buf_chan[buf_rd_ptr];
   assign res_data  = buf_data[buf_rd_ptr];
   assign res_pop   = res_valid && res_ready;

   always_ff @(posedge clk_in) begin
      if (s1_valid) begin
         buf_chan[buf_wr_ptr] <= s1_chan;
         buf_data[buf_wr_ptr] <= result;
      end
   end

   always_ff @(posedge clk_in) begin
      if (reset) begin
         buf_wr_ptr   <= '0;
         buf_rd_ptr   <= '0;
         buf_count    <= '0;
         instr.credit <= 1'b0;
      end else begin
         if (s1_valid) buf_wr_ptr <= buf_wr_ptr + 1'b1;
         if (res_pop)  buf_rd_ptr <= buf_rd_ptr + 1'b1;
         case ({s1_valid, res_pop})
            2'b10:   buf_count <= buf_count + 1'b1;
            2'b01:   buf_count <= buf_count - 1'b1;
            default: buf_count <= buf_count;
         endcase
         // Each popped result hands one slot back to the dispatcher
         instr.credit <= res_pop;
      end
   end

endmodule

// File: hdl/pid_pkg.sv
package pid_pkg;

   // --------------------------------------------------
   // Datapath widths and counts
   // --------------------------------------------------

   // Number of PID output channels and the width of a channel index
   localparam int N_CHAN = 8;
   localparam int W_CHAN = 3;

   // ADC source tag and signed sample widths
   localparam int W_SRC  = 5;
   localparam int W_DATA = 18;

   // Proportional gain is unsigned, integrator and result are signed and wrap
   localparam int W_KP  = 8;
   localparam int W_ACC = 24;

   // Sample FIFO depth and result buffer depth (also the initial credit count)
   localparam int FIFO_DEPTH = 16;
   localparam int N_CREDIT   = 4;

   // Derived pointer and counter widths
   localparam int W_FIFO_PTR = $clog2(FIFO_DEPTH);
   localparam int W_RES_PTR  = $clog2(N_CREDIT);
   localparam int W_CREDIT   = $clog2(N_CREDIT + 1);
   localparam logic [W_CREDIT-1:0] CREDIT_INIT = N_CREDIT[W_CREDIT-1:0];

   // A source select with the top bit set matches no ADC source tag
   localparam logic [W_SRC:0] NULL_SRC = {1'b1, {W_SRC{1'b0}}};

   // Register opcodes on the configuration write bus
   typedef enum logic [1:0] {
      CFG_SRC_SEL  = 2'd0,
      CFG_CHAN_EN  = 2'd1,
      CFG_SETPOINT = 2'd2,
      CFG_KP       = 2'd3
   } cfg_addr_t;

endpackage

// File: hdl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo (
   input  logic                        clk_in,
   input  logic                        reset,
   input  logic                        in_valid,
   input  logic [pid_pkg::W_SRC-1:0]   in_src,
   input  logic [pid_pkg::W_DATA-1:0]  in_data,
   input  logic                        pop,
   output logic                        head_valid,
   output logic [pid_pkg::W_SRC-1:0]   head_src,
   output logic [pid_pkg::W_DATA-1:0]  head_data,
   output logic                        full
);

   // --------------------------------------------------
   // Storage and pointers
   // --------------------------------------------------

   // Source tag and sample are stored side by side in one slot
   logic [pid_pkg::W_SRC-1:0]      src_mem  [pid_pkg::FIFO_DEPTH];
   logic [pid_pkg::W_DATA-1:0]     data_mem [pid_pkg::FIFO_DEPTH];
   logic [pid_pkg::W_FIFO_PTR-1:0] wr_ptr;
   logic [pid_pkg::W_FIFO_PTR-1:0] rd_ptr;

   // One extra bit so that a full buffer is distinct from an empty one
   logic [pid_pkg::W_FIFO_PTR:0]   count;
   logic                           push;
   logic                           drop;

   // Writes while full are lost, pops on an empty buffer are ignored
   assign push = in_valid && !full;
   assign drop = pop && head_valid;

   // Depth is a power of two, so the count MSB alone flags a full buffer
   assign full       = count[pid_pkg::W_FIFO_PTR];
   assign head_valid = (count != '0);

   // The head is read straight from the array, with no read latency
   assign head_src  = src_mem[rd_ptr];
   assign head_data = data_mem[rd_ptr];

   always_ff @(posedge clk_in) begin
      if (push) begin
         src_mem[wr_ptr]  <= in_src;
         data_mem[wr_ptr] <= in_data;
      end
   end

   // Pointers wrap naturally at the array size
   always_ff @(posedge clk_in) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (drop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, drop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: test/pid_core_asserts.sv
`timescale 1ns/1ps

// Checks shared by the dispatcher credit counter and the filter result buffer
module pid_core_asserts (
   input  logic                          clk_in,
   input  logic                          reset,
   input  logic [pid_pkg::W_CREDIT-1:0]  level,
   input  logic                          take,
   input  logic                          out_valid,
   input  logic                          out_ready,
   input  logic [pid_pkg::W_ACC-1:0]     out_data
);

   // Credits or free result slots never leave 0..N_CREDIT, so no overflow
   level_in_range: assert property (@(posedge clk_in) disable iff (reset)
      level <= pid_pkg::N_CREDIT)
      else $error("Count outside the range of the credit limit");

   // An issue beat or a buffer push needs a nonzero count
   take_needs_level: assert property (@(posedge clk_in) disable iff (reset)
      take |-> (level != '0))
      else $error("Beat taken while the count is zero");

   // A stalled head or result holds its value until it is taken
   stall_holds_data: assert property (@(posedge clk_in) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
      else $error("Value changed while stalled");

endmodule

// Dispatcher side, credits against instruction beats and the held FIFO head
bind instr_dispatch pid_core_asserts credit_chk (
   .clk_in    (clk_in),
   .reset     (reset),
   .level     (credits),
   .take      (instr.valid),
   .out_valid (head_valid),
   .out_ready (pop),
   .out_data  ({{(pid_pkg::W_ACC - pid_pkg::W_DATA){1'b0}}, head_data})
);

// Filter side, free buffer slots against pushes, and the result handshake
bind pid_filter pid_core_asserts buffer_chk (
   .clk_in    (clk_in),
   .reset     (reset),
   .level     (pid_pkg::CREDIT_INIT - buf_count),
   .take      (s1_valid),
   .out_valid (res_valid),
   .out_ready (res_ready),
   .out_data  (res_data)
);

// File: test/pid_core_tb.sv
`timescale 1ns/1ps

module pid_core_tb;

   // Sample counts per test feed the watchdog limit
   localparam int N_SAMPLES = 2 + 20 + 60 + 400 + 40 + 300;
   localparam int WATCHDOG_CYCLES = N_SAMPLES * (pid_pkg::N_CHAN + 2) * 40 + 2000;

   logic                        clk_in;
   logic                        reset;
   logic                        in_valid;
   logic [pid_pkg::W_SRC-1:0]   in_src;
   logic [pid_pkg::W_DATA-1:0]  in_data;
   logic                        wr_en;
   pid_pkg::cfg_addr_t          wr_addr;
   logic [pid_pkg::W_CHAN-1:0]  wr_chan;
   logic [pid_pkg::W_DATA-1:0]  wr_data;
   logic                        res_ready;
   logic                        in_full;
   logic                        res_valid;
   logic [pid_pkg::W_CHAN-1:0]  res_chan;
   logic [pid_pkg::W_ACC-1:0]   res_data;

   // --------------------------------------------------
   // Reference model state
   // --------------------------------------------------
   logic [5:0]   m_src [pid_pkg::N_CHAN];
   logic         m_en  [pid_pkg::N_CHAN];
   logic [17:0]  m_sp  [pid_pkg::N_CHAN];
   logic [7:0]   m_kp  [pid_pkg::N_CHAN];
   logic [23:0]  m_int [pid_pkg::N_CHAN];
   // Expected results in arrival order, channel above value
   logic [26:0]  exp_q [$];

   int     errors;
   int     n_results;
   logic   hold_ready;
   logic   saw_full;
   string  test_name;

   pid_core_top dut0 (.*);

   initial begin
      clk_in = 1'b0;
      forever #5 clk_in = ~clk_in;
   end

   // Applies the PI rule with every sum wrapped to 24 bits
   function automatic void model_sample(logic [4:0] src, logic [17:0] data);
      logic [23:0] err;
      logic [23:0] prod;
      for (int ch = 0; ch < pid_pkg::N_CHAN; ch++) begin
         if (m_src[ch] == {1'b0, src} && m_en[ch]) begin
            err       = {{6{data[17]}}, data} - {{6{m_sp[ch][17]}}, m_sp[ch]};
            prod      = err * {16'b0, m_kp[ch]};
            m_int[ch] = m_int[ch] + err;
            exp_q.push_back({ch[2:0], prod + m_int[ch]});
         end
      end
   endfunction

   // One clock, inputs changed 1 ns after the edge
   task automatic tick();
      @(posedge clk_in);
      #1;
      in_valid = 1'b0;
      wr_en    = 1'b0;
      if (hold_ready) res_ready = 1'b0;
      else res_ready = ($urandom % 4) != 0;
   endtask

   task automatic write_cfg(pid_pkg::cfg_addr_t addr, int ch, logic [17:0] data);
      tick();
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_chan = ch[2:0];
      wr_data = data;
      case (addr)
         pid_pkg::CFG_SRC_SEL:  m_src[ch] = data[5:0];
         pid_pkg::CFG_CHAN_EN:  m_en[ch]  = data[0];
         pid_pkg::CFG_SETPOINT: m_sp[ch]  = data;
         default:               m_kp[ch]  = data[7:0];
      endcase
   endtask

   // Sources come from a pool of n_src, now and then none matches
   task automatic random_config(int n_src);
      logic [5:0] sel;
      for (int ch = 0; ch < pid_pkg::N_CHAN; ch++) begin
         sel = ($urandom % 5 == 0) ? pid_pkg::NULL_SRC : 6'($urandom % n_src);
         write_cfg(pid_pkg::CFG_SRC_SEL, ch, {12'($urandom), sel});
         write_cfg(pid_pkg::CFG_CHAN_EN, ch, 18'({$urandom % 4 != 0}));
         write_cfg(pid_pkg::CFG_SETPOINT, ch, 18'($urandom));
         write_cfg(pid_pkg::CFG_KP, ch, 18'($urandom));
      end
   endtask

   // Waits for room in the FIFO, so no write is ever dropped
   task automatic send_sample(logic [4:0] src, logic [17:0] data);
      tick();
      while (in_full) tick();
      in_valid = 1'b1;
      in_src   = src;
      in_data  = data;
      model_sample(src, data);
      if ($urandom % 4 == 0) tick();
   endtask

   // Mostly configured sources, the rest anywhere in the tag space
   task automatic send_burst(int count, int n_src);
      for (int i = 0; i < count; i++) begin
         if ($urandom % 8 != 0) send_sample(5'($urandom % n_src), 18'($urandom));
         else send_sample(5'($urandom), 18'($urandom));
      end
   endtask

   // Idle means nothing expected, nothing queued and nothing presented
   task automatic wait_idle();
      tick();
      while (exp_q.size() != 0 || dut0.head_valid || res_valid) tick();
      repeat (3) tick();
   endtask

   // Handshake compare at the falling edge, where both sides are settled
   always @(negedge clk_in) begin
      logic [26:0] exp;
      if (!reset && res_valid && res_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected result on channel %0d in test %s", res_chan, test_name);
         end else begin
            exp = exp_q.pop_front();
            n_results++;
            if (res_chan !== exp[26:24] || res_data !== exp[23:0]) begin
               errors++;
               $display("Fail %s: expected chan %0d data %h, actual chan %0d data %h",
                        test_name, exp[26:24], exp[23:0], res_chan, res_data);
            end
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_in);
      $display("Timeout: results stopped arriving in test %s", test_name);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      void'($urandom(32'he794));
      {in_valid, in_src, in_data, wr_en, wr_chan, wr_data} = '0;
      wr_addr    = pid_pkg::CFG_SRC_SEL;
      res_ready  = 1'b0;
      hold_ready = 1'b0;
      errors     = 0;
      n_results  = 0;
      test_name  = "reset";
      for (int ch = 0; ch < pid_pkg::N_CHAN; ch++) begin
         m_src[ch] = pid_pkg::NULL_SRC;
         {m_en[ch], m_sp[ch], m_kp[ch], m_int[ch]} = '0;
      end
      reset = 1'b1;
      repeat (4) @(posedge clk_in);
      #1 reset = 1'b0;

      // All sources are null, so these samples must vanish
      tick();
      if (res_valid !== 1'b0) begin
         errors++;
         $display("Fail reset: expected res_valid 0, actual %b", res_valid);
      end
      if (in_full !== 1'b0) begin
         errors++;
         $display("Fail reset: expected in_full 0, actual %b", in_full);
      end
      send_burst(2, 4);
      wait_idle();

      // Source 5 fans out to three channels, channel 2 stays disabled
      test_name = "fanout";
      for (int ch = 1; ch < 7; ch++) begin
         if (ch == 1 || ch == 2 || ch == 3 || ch == 6) begin
            write_cfg(pid_pkg::CFG_SRC_SEL, ch, 18'd5);
            write_cfg(pid_pkg::CFG_CHAN_EN, ch, 18'(ch != 2));
            write_cfg(pid_pkg::CFG_SETPOINT, ch, 18'($urandom));
            write_cfg(pid_pkg::CFG_KP, ch, 18'($urandom));
         end
      end
      for (int i = 0; i < 20; i++) send_sample(5'd5, 18'($urandom));
      wait_idle();

      test_name = "enable_null";
      random_config(4);
      send_burst(60, 32);
      wait_idle();

      test_name = "pi_arith";
      random_config(4);
      send_burst(400, 4);
      wait_idle();

      // Ready held low fills the result buffer, then the FIFO
      test_name = "backpressure";
      write_cfg(pid_pkg::CFG_SRC_SEL, 0, 18'd2);
      write_cfg(pid_pkg::CFG_CHAN_EN, 0, 18'd1);
      hold_ready = 1'b1;
      saw_full   = 1'b0;
      for (int i = 0; i < 40 && !saw_full; i++) begin
         tick();
         if (in_full) begin
            saw_full = 1'b1;
         end else begin
            in_valid = 1'b1;
            in_src   = 5'd2;
            in_data  = 18'($urandom);
            model_sample(5'd2, in_data);
         end
      end
      if (!saw_full) begin
         errors++;
         $display("The sample FIFO never reported full while results were held back");
      end
      hold_ready = 1'b0;
      wait_idle();

      test_name = "reconfig";
      for (int round = 0; round < 6; round++) begin
         random_config(3 + round);
         send_burst(50, 3 + round);
         wait_idle();
      end

      if (n_results == 0) begin
         errors++;
         $display("No results were received during the run");
      end
      $display("Errors: %0d, results checked: %0d", errors, n_results);
      if (errors == 0) $display("TEST RESULT: PASS");
      else $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: vlog.f
hdl/pid_pkg.sv
hdl/instr_if.sv
hdl/sample_fifo.sv
hdl/instr_dispatch.sv
hdl/pid_filter.sv
hdl/pid_core_top.sv
test/pid_core_asserts.sv
test/pid_core_tb.sv
